/* src/lsu_pkg.sv */
package lsu_pkg;

    localparam int num_lanes      = 4;
    localparam int xlen           = 32;
    localparam int word_bytes     = 4;
    localparam int align_bits     = 2;
    localparam int word_addr_bits = 30;
    localparam int wid_bits       = 2;
    localparam int pc_bits        = 30;
    localparam int reg_bits       = 5;
    localparam int offset_bits    = 12;

    // wsize encoding: 0 byte, 1 half, 2 word
    typedef struct packed {
        logic       is_fence;
        logic       is_unsigned;
        logic [1:0] wsize;
    } lsu_op_t;

    typedef struct packed {
        logic [wid_bits-1:0]                  wid;
        logic [pc_bits-1:0]                   pc;
        logic [num_lanes-1:0]                 tmask;
        logic                                 wb;
        logic [reg_bits-1:0]                  rd;
        lsu_op_t                              op;
        logic                                 is_store;
        logic [offset_bits-1:0]               offset;
        logic [num_lanes-1:0][xlen-1:0]       rs1_data;
        logic [num_lanes-1:0][xlen-1:0]       rs2_data;
    } exec_req_t;

    // everything the response path needs to rebuild the commit
    typedef struct packed {
        logic [wid_bits-1:0]                  wid;
        logic [pc_bits-1:0]                   pc;
        logic                                 wb;
        logic [reg_bits-1:0]                  rd;
        lsu_op_t                              op;
        logic [num_lanes-1:0][align_bits-1:0] align;
    } lsu_tag_t;

    typedef struct packed {
        logic                                 rw;
        logic                                 flush;
        logic [num_lanes-1:0]                 mask;
        logic [num_lanes-1:0][word_addr_bits-1:0] addr;
        logic [num_lanes-1:0][word_bytes-1:0] byteen;
        logic [num_lanes-1:0][xlen-1:0]       data;
        lsu_tag_t                             tag;
    } mem_req_t;

    typedef struct packed {
        logic [num_lanes-1:0]                 mask;
        logic [num_lanes-1:0][xlen-1:0]       data;
        lsu_tag_t                             tag;
    } mem_rsp_t;

    typedef struct packed {
        logic [wid_bits-1:0]                  wid;
        logic [pc_bits-1:0]                   pc;
        logic [num_lanes-1:0]                 tmask;
        logic                                 wb;
        logic [reg_bits-1:0]                  rd;
        logic [num_lanes-1:0][xlen-1:0]       data;
    } commit_t;

endpackage

/* src/lsu_skid_buffer.sv */
module lsu_skid_buffer #(
    parameter type payload_t = lsu_pkg::commit_t
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     valid_in,
    input  payload_t data_in,
    output logic     ready_in,
    output logic     valid_out,
    output payload_t data_out,
    input  logic     ready_out
);

    logic     skid_valid;
    payload_t skid_data;

    // second entry only fills while the output is stalled
    assign ready_in = ~skid_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (~valid_out || ready_out) begin
            if (skid_valid) begin
                valid_out  <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                valid_out <= valid_in;
            end
        end else if (valid_in && ~skid_valid) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (~valid_out || ready_out) begin
            data_out <= skid_valid ? skid_data : data_in;
        end
        if (valid_in && ~skid_valid) begin
            skid_data <= data_in;
        end
    end

    a_hold_stable: assert property (
        @(posedge clk) disable iff (reset)
        valid_out && ~ready_out |=> valid_out && $stable(data_out)
    ) else $error("skid buffer output changed while stalled");

endmodule

/* src/lsu_req_format.sv */
module lsu_req_format (
    input  logic               exec_valid,
    input  lsu_pkg::exec_req_t exec_req,
    output lsu_pkg::mem_req_t  mem_req
);

    logic [lsu_pkg::xlen-1:0]      offset_ext;
    logic [lsu_pkg::num_lanes-1:0][lsu_pkg::xlen-1:0]       full_addr;
    logic [lsu_pkg::num_lanes-1:0][lsu_pkg::align_bits-1:0] align;

    assign offset_ext = {
        {(lsu_pkg::xlen - lsu_pkg::offset_bits){exec_req.offset[lsu_pkg::offset_bits-1]}},
        exec_req.offset
    };

    always_comb begin
        mem_req       = '0;
        mem_req.rw    = exec_req.is_store;
        mem_req.flush = exec_req.op.is_fence;
        mem_req.mask  = exec_req.tmask;

        for (int i = 0; i < lsu_pkg::num_lanes; i++) begin
            full_addr[i] = exec_req.rs1_data[i] + offset_ext;
            align[i]     = full_addr[i][lsu_pkg::align_bits-1:0];
            mem_req.addr[i] = full_addr[i][lsu_pkg::xlen-1:lsu_pkg::align_bits];

            case (exec_req.op.wsize)
                2'd0: mem_req.byteen[i] = lsu_pkg::word_bytes'(1) << align[i];
                2'd1: mem_req.byteen[i] = align[i][1] ? 4'b1100 : 4'b0011;
                default: mem_req.byteen[i] = '1;
            endcase

            // move the store bytes up to their lane position
            mem_req.data[i] = exec_req.rs2_data[i] << {align[i], 3'b000};
        end

        mem_req.tag.wid   = exec_req.wid;
        mem_req.tag.pc    = exec_req.pc;
        mem_req.tag.wb    = exec_req.wb;
        mem_req.tag.rd    = exec_req.rd;
        mem_req.tag.op    = exec_req.op;
        mem_req.tag.align = align;
    end

    // misaligned accesses are not split, so they must never reach here
    for (genvar i = 0; i < lsu_pkg::num_lanes; i++) begin : g_align_chk
        a_aligned: assert final (
            ~(exec_valid && exec_req.tmask[i] && ~exec_req.op.is_fence)
            || (exec_req.op.wsize == 2'd0)
            || (exec_req.op.wsize == 2'd1 && ~align[i][0])
            || (align[i] == '0)
        ) else $error("misaligned access lane %0d pc %h wsize %0d",
                      i, exec_req.pc, exec_req.op.wsize);
    end

endmodule

/* src/lsu_issue_ctrl.sv */
module lsu_issue_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  logic               exec_valid,
    input  lsu_pkg::exec_req_t exec_req,
    output logic               exec_ready,
    output logic               mem_req_valid,
    input  logic               mem_req_ready,
    input  logic               fence_done,
    output logic               store_valid,
    output lsu_pkg::commit_t   store_commit,
    input  logic               store_ready
);

    logic             fence_lock;
    logic             req_is_fence;
    logic             req_is_store;
    logic             store_buf_ready;
    logic             store_buf_valid;
    logic             store_ok;
    logic             mem_fire;
    lsu_pkg::commit_t store_entry;

    assign req_is_fence = exec_req.op.is_fence;
    assign req_is_store = exec_req.is_store;

    // a store needs room in the commit buffer before it may leave
    assign store_ok = ~req_is_store || store_buf_ready;

    assign mem_req_valid = exec_valid && ~fence_lock && store_ok;
    assign exec_ready    = mem_req_ready && ~fence_lock && store_ok;
    assign mem_fire      = mem_req_valid && mem_req_ready;

    // enqueue in the same cycle the store goes to memory
    assign store_buf_valid = mem_fire && req_is_store;

    always_ff @(posedge clk) begin
        if (reset) begin
            fence_lock <= 1'b0;
        end else if (mem_fire && req_is_fence) begin
            fence_lock <= 1'b1;
        end else if (fence_done) begin
            fence_lock <= 1'b0;
        end
    end

    always_comb begin
        store_entry       = '0;
        store_entry.wid   = exec_req.wid;
        store_entry.pc    = exec_req.pc;
        store_entry.tmask = exec_req.tmask;
    end

    lsu_skid_buffer #(
        .payload_t (lsu_pkg::commit_t)
    ) store_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (store_buf_valid),
        .data_in   (store_entry),
        .ready_in  (store_buf_ready),
        .valid_out (store_valid),
        .data_out  (store_commit),
        .ready_out (store_ready)
    );

    // nothing issues between a fence and its response
    a_fence_block: assert property (
        @(posedge clk) disable iff (reset)
        mem_fire && req_is_fence |=> (~mem_fire && ~exec_ready) until_with fence_done
    ) else $error("request issued while a fence was outstanding");

endmodule

/* src/lsu_rsp_format.sv */
module lsu_rsp_format (
    input  logic              clk,
    input  logic              reset,
    input  logic              mem_rsp_valid,
    input  lsu_pkg::mem_rsp_t mem_rsp,
    output logic              mem_rsp_ready,
    output logic              fence_done,
    output logic              load_valid,
    output lsu_pkg::commit_t  load_commit,
    input  logic              load_ready
);

    lsu_pkg::lsu_tag_t tag;
    lsu_pkg::commit_t  rsp_entry;
    logic [lsu_pkg::num_lanes-1:0][15:0] lane_half;
    logic [lsu_pkg::num_lanes-1:0][7:0]  lane_byte;

    assign tag        = mem_rsp.tag;
    assign fence_done = mem_rsp_valid && mem_rsp_ready && tag.op.is_fence;

    always_comb begin
        rsp_entry       = '0;
        rsp_entry.wid   = tag.wid;
        rsp_entry.pc    = tag.pc;
        rsp_entry.tmask = mem_rsp.mask;
        // fences never write a register
        rsp_entry.wb    = tag.wb && ~tag.op.is_fence;
        rsp_entry.rd    = tag.rd;

        for (int i = 0; i < lsu_pkg::num_lanes; i++) begin
            lane_half[i] = tag.align[i][1] ? mem_rsp.data[i][31:16] : mem_rsp.data[i][15:0];
            lane_byte[i] = tag.align[i][0] ? lane_half[i][15:8] : lane_half[i][7:0];

            case (tag.op.wsize)
                2'd0: rsp_entry.data[i] = tag.op.is_unsigned
                                        ? {24'd0, lane_byte[i]}
                                        : {{24{lane_byte[i][7]}}, lane_byte[i]};
                2'd1: rsp_entry.data[i] = tag.op.is_unsigned
                                        ? {16'd0, lane_half[i]}
                                        : {{16{lane_half[i][15]}}, lane_half[i]};
                default: rsp_entry.data[i] = mem_rsp.data[i];
            endcase
        end
    end

    lsu_skid_buffer #(
        .payload_t (lsu_pkg::commit_t)
    ) rsp_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (mem_rsp_valid),
        .data_in   (rsp_entry),
        .ready_in  (mem_rsp_ready),
        .valid_out (load_valid),
        .data_out  (load_commit),
        .ready_out (load_ready)
    );

endmodule

/* src/lsu_commit_arb.sv */
module lsu_commit_arb (
    input  logic             clk,
    input  logic             reset,
    input  logic             store_valid,
    input  lsu_pkg::commit_t store_commit,
    output logic             store_ready,
    input  logic             load_valid,
    input  lsu_pkg::commit_t load_commit,
    output logic             load_ready,
    output logic             commit_valid,
    output lsu_pkg::commit_t commit,
    input  logic             commit_ready
);

    logic out_free;
    logic last_store;
    logic grant_store;
    logic grant_load;

    assign out_free = ~commit_valid || commit_ready;

    // the side that won last gives way on a tie
    assign grant_store = out_free && store_valid && (~load_valid || ~last_store);
    assign grant_load  = out_free && load_valid && (~store_valid || last_store);

    assign store_ready = grant_store;
    assign load_ready  = grant_load;

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
            last_store   <= 1'b0;
        end else begin
            if (out_free) begin
                commit_valid <= grant_store || grant_load;
            end
            if (grant_store) begin
                last_store <= 1'b1;
            end else if (grant_load) begin
                last_store <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_store) begin
            commit <= store_commit;
        end else if (grant_load) begin
            commit <= load_commit;
        end
    end

    // a side left waiting wins the next grant
    a_store_yields: assert property (
        @(posedge clk) disable iff (reset)
        grant_store && load_valid |=> ~grant_store
    ) else $error("store granted again while a load was waiting");

    a_load_yields: assert property (
        @(posedge clk) disable iff (reset)
        grant_load && store_valid |=> ~grant_load
    ) else $error("load granted again while a store was waiting");

endmodule

/* src/lsu_slice.sv */
module lsu_slice (
    input  logic               clk,
    input  logic               reset,

    input  logic               exec_valid,
    input  lsu_pkg::exec_req_t exec_req,
    output logic               exec_ready,

    output logic               mem_req_valid,
    output lsu_pkg::mem_req_t  mem_req,
    input  logic               mem_req_ready,

    input  logic               mem_rsp_valid,
    input  lsu_pkg::mem_rsp_t  mem_rsp,
    output logic               mem_rsp_ready,

    output logic               commit_valid,
    output lsu_pkg::commit_t   commit,
    input  logic               commit_ready
);

    logic             fence_done;
    logic             store_valid;
    logic             store_ready;
    lsu_pkg::commit_t store_commit;
    logic             load_valid;
    logic             load_ready;
    lsu_pkg::commit_t load_commit;

    lsu_req_format req_format (
        .exec_valid (exec_valid),
        .exec_req   (exec_req),
        .mem_req    (mem_req)
    );

    lsu_issue_ctrl issue_ctrl (
        .clk           (clk),
        .reset         (reset),
        .exec_valid    (exec_valid),
        .exec_req      (exec_req),
        .exec_ready    (exec_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .fence_done    (fence_done),
        .store_valid   (store_valid),
        .store_commit  (store_commit),
        .store_ready   (store_ready)
    );

    lsu_rsp_format rsp_format (
        .clk           (clk),
        .reset         (reset),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready),
        .fence_done    (fence_done),
        .load_valid    (load_valid),
        .load_commit   (load_commit),
        .load_ready    (load_ready)
    );

    lsu_commit_arb commit_arb (
        .clk          (clk),
        .reset        (reset),
        .store_valid  (store_valid),
        .store_commit (store_commit),
        .store_ready  (store_ready),
        .load_valid   (load_valid),
        .load_commit  (load_commit),
        .load_ready   (load_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

endmodule

/* tests/tb_lsu_slice.sv */
module tb_lsu_slice;

    localparam int max_cycles = 4000;

    logic                clk = 1'b0;
    logic                reset;
    logic                exec_valid;
    lsu_pkg::exec_req_t  exec_req;
    logic                exec_ready;
    logic                mem_req_valid;
    lsu_pkg::mem_req_t   mem_req;
    logic                mem_req_ready;
    logic                mem_rsp_valid;
    lsu_pkg::mem_rsp_t   mem_rsp;
    logic                mem_rsp_ready;
    logic                commit_valid;
    lsu_pkg::commit_t    commit;
    logic                commit_ready;

    int                  errors = 0;
    int                  cycles = 0;
    int unsigned         seed = 49;
    logic [29:0]         pc_next = 30'h40;
    logic                stall_mode = 1'b0;
    logic                log_reqs = 1'b0;
    logic                fence_pending = 1'b0;
    logic [31:0]         mem [1024];
    logic [31:0]         shadow [1024];
    lsu_pkg::mem_req_t   req_log [$];
    lsu_pkg::mem_rsp_t   pend_rsp [$];
    int                  pend_due [$];
    lsu_pkg::commit_t    got_q [$];
    lsu_pkg::commit_t    exp_q [$];
    logic [29:0]         load_pcs [$];

    always #2 clk = ~clk;

    lsu_slice uut (.*);

    function automatic int unsigned lcg();
        seed = seed * 1103515245 + 12345;
        return (seed >> 16) & 32'h7fff;
    endfunction

    function automatic logic [31:0] fill_word(int a);
        return (a * 32'h9e3779b1) ^ 32'h5a0f3c96;
    endfunction

    function automatic logic [31:0] lane_addr(lsu_pkg::exec_req_t r, int i);
        return r.rs1_data[i] + {{20{r.offset[11]}}, r.offset};
    endfunction

    function automatic logic [31:0] load_value(logic [31:0] w, logic [1:0] al,
                                               logic [1:0] ws, logic uns);
        logic [31:0] sh;
        sh = w >> (8 * al);
        if (ws == 2'd0)
            return uns ? {24'd0, sh[7:0]} : 32'($signed(sh[7:0]));
        if (ws == 2'd1)
            return uns ? {16'd0, sh[15:0]} : 32'($signed(sh[15:0]));
        return w;
    endfunction

    // expected memory request built from the addressing rules
    function automatic lsu_pkg::mem_req_t expect_req(lsu_pkg::exec_req_t r);
        lsu_pkg::mem_req_t m;
        logic [31:0]       a;
        m = '0;
        m.rw = r.is_store;
        m.flush = r.op.is_fence;
        m.mask = r.tmask;
        m.tag.wid = r.wid;
        m.tag.pc = r.pc;
        m.tag.wb = r.wb;
        m.tag.rd = r.rd;
        m.tag.op = r.op;
        for (int i = 0; i < lsu_pkg::num_lanes; i++) begin
            a = lane_addr(r, i);
            m.addr[i] = a[31:2];
            m.tag.align[i] = a[1:0];
            m.byteen[i] = (r.op.wsize == 2'd0) ? 4'b0001 << a[1:0]
                        : (r.op.wsize == 2'd1) ? 4'b0011 << a[1:0] : 4'hf;
            m.data[i] = r.rs2_data[i] << (8 * a[1:0]);
        end
        return m;
    endfunction

    function automatic lsu_pkg::exec_req_t make_req(logic st, logic [1:0] ws, logic uns,
                                                    logic [31:0] base, logic [11:0] off,
                                                    logic [3:0] tmask);
        lsu_pkg::exec_req_t r;
        r = '0;
        r.pc = pc_next;
        pc_next = pc_next + 1;
        r.wid = r.pc[1:0];
        r.rd = r.pc[4:0];
        r.wb = ~st;
        r.is_store = st;
        r.op.wsize = ws;
        r.op.is_unsigned = uns;
        r.offset = off;
        r.tmask = tmask;
        for (int i = 0; i < lsu_pkg::num_lanes; i++) begin
            r.rs1_data[i] = base + 16 * i;
            r.rs2_data[i] = (r.pc * 32'h01000193) ^ (i * 32'h11111111) ^ 32'h80808080;
        end
        return r;
    endfunction

    task automatic check_commit(lsu_pkg::commit_t got, lsu_pkg::commit_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: commit pc %h got %h expected %h", $time, exp.pc, got, exp);
        end
    endtask

    task automatic check_mem_req(lsu_pkg::mem_req_t got, lsu_pkg::mem_req_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: mem_req pc %h got %h expected %h",
                     $time, exp.tag.pc, got, exp);
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic issue(lsu_pkg::exec_req_t r);
        lsu_pkg::commit_t  e;
        lsu_pkg::mem_req_t m;
        logic [31:0]       a;
        exec_valid = 1'b1;
        exec_req = r;
        @(posedge clk);
        while (!exec_ready) @(posedge clk);
        @(negedge clk);
        exec_valid = 1'b0;
        m = expect_req(r);
        e = '0;
        e.wid = r.wid;
        e.pc = r.pc;
        e.tmask = r.tmask;
        for (int i = 0; i < lsu_pkg::num_lanes; i++) begin
            a = lane_addr(r, i);
            if (r.tmask[i] && r.is_store) begin
                for (int b = 0; b < 4; b++)
                    if (m.byteen[i][b]) shadow[a[11:2]][8*b +: 8] = m.data[i][8*b +: 8];
            end else if (r.tmask[i] && !r.op.is_fence) begin
                e.data[i] = load_value(shadow[a[11:2]], a[1:0], r.op.wsize, r.op.is_unsigned);
            end
        end
        if (!r.is_store) begin
            e.wb = r.wb && !r.op.is_fence;
            e.rd = r.rd;
            if (!r.op.is_fence) load_pcs.push_back(r.pc);
        end
        exp_q.push_back(e);
    endtask

    // match every outstanding commit by pc
    task automatic drain();
        lsu_pkg::commit_t g;
        int               k;
        while (exp_q.size() > 0) begin
            @(negedge clk);
            while (got_q.size() > 0) begin
                g = got_q.pop_front();
                k = -1;
                foreach (exp_q[j]) if (exp_q[j].pc == g.pc) k = j;
                if (k < 0) begin
                    errors++;
                    $display("unexpected commit for pc %h at time %0t", g.pc, $time);
                end else begin
                    check_commit(g, exp_q[k]);
                    exp_q.delete(k);
                    if (load_pcs.size() > 0 && load_pcs[0] == g.pc) begin
                        void'(load_pcs.pop_front());
                    end else begin
                        foreach (load_pcs[j]) if (load_pcs[j] == g.pc) begin
                            errors++;
                            $display("load pc %h committed out of order", g.pc);
                            load_pcs.delete(j);
                        end
                    end
                end
            end
        end
    endtask

    // memory model and output monitor
    always @(posedge clk) begin
        lsu_pkg::mem_rsp_t rsp;
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, %0d errors", cycles, errors);
            $display("Finished with errors");
            $finish;
        end else if (!reset) begin
            if (mem_req_valid && mem_req_ready) begin
                if (fence_pending) begin
                    errors++;
                    $display("memory request issued while a fence was outstanding");
                end
                if (log_reqs) req_log.push_back(mem_req);
                if (mem_req.rw) begin
                    for (int i = 0; i < 4; i++)
                        for (int b = 0; b < 4; b++)
                            if (mem_req.mask[i] && mem_req.byteen[i][b])
                                mem[mem_req.addr[i][9:0]][8*b +: 8] = mem_req.data[i][8*b +: 8];
                end else begin
                    rsp = '0;
                    rsp.mask = mem_req.mask;
                    rsp.tag = mem_req.tag;
                    for (int i = 0; i < 4; i++)
                        if (mem_req.mask[i] && !mem_req.flush)
                            rsp.data[i] = mem[mem_req.addr[i][9:0]];
                    pend_rsp.push_back(rsp);
                    pend_due.push_back(cycles + 1 + lcg() % 6);
                    if (mem_req.flush) fence_pending = 1'b1;
                end
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                if (pend_rsp[0].tag.op.is_fence) fence_pending = 1'b0;
                void'(pend_rsp.pop_front());
                void'(pend_due.pop_front());
            end
            if (commit_valid && commit_ready) got_q.push_back(commit);
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            mem_req_ready = !stall_mode || (lcg() % 4 != 0);
            commit_ready = !stall_mode || (lcg() % 3 != 0);
            if (pend_rsp.size() > 0 && pend_due[0] <= cycles) begin
                mem_rsp_valid = 1'b1;
                mem_rsp = pend_rsp[0];
            end else begin
                mem_rsp_valid = 1'b0;
            end
        end
    end

    task automatic test_word_access();
        issue(make_req(1'b1, 2'd2, 1'b0, 32'h100, 12'h0, 4'hf));
        issue(make_req(1'b0, 2'd2, 1'b0, 32'h100, 12'h0, 4'hf));
        drain();
    endtask

    task automatic test_req_format();
        lsu_pkg::exec_req_t r;
        lsu_pkg::mem_req_t  want [$];
        log_reqs = 1'b1;
        req_log.delete();
        for (int ws = 0; ws < 2; ws++) begin
            for (int al = 0; al < 4; al += ws + 1) begin
                r = make_req(1'b1, ws, 1'b0, 32'h200 + al, 12'h0, 4'hf);
                issue(r);
                want.push_back(expect_req(r));
                // negative offset lands on the same alignment
                r = make_req(1'b1, ws, 1'b0, 32'h250 + al, 12'hff0, 4'hf);
                issue(r);
                want.push_back(expect_req(r));
            end
        end
        drain();
        log_reqs = 1'b0;
        if (req_log.size() != want.size()) begin
            errors++;
            $display("saw %0d memory requests, wanted %0d", req_log.size(), want.size());
        end else begin
            foreach (want[j]) check_mem_req(req_log[j], want[j]);
        end
    endtask

    task automatic test_subword_loads();
        lsu_pkg::exec_req_t r;
        r = make_req(1'b1, 2'd2, 1'b0, 32'h300, 12'h0, 4'hf);
        for (int i = 0; i < 4; i++) r.rs2_data[i] = 32'h8f9eadbc ^ (i << 4);
        issue(r);
        for (int ws = 0; ws < 2; ws++)
            for (int uns = 0; uns < 2; uns++)
                for (int al = 0; al < 4; al += ws + 1)
                    issue(make_req(1'b0, ws, uns, 32'h300 + al, 12'h0, 4'hf));
        drain();
    endtask

    task automatic test_partial_mask();
        issue(make_req(1'b1, 2'd2, 1'b0, 32'h400, 12'h0, 4'b0101));
        issue(make_req(1'b0, 2'd2, 1'b0, 32'h400, 12'h0, 4'hf));
        drain();
    endtask

    task automatic test_fence();
        lsu_pkg::exec_req_t r;
        r = make_req(1'b0, 2'd2, 1'b0, 32'h100, 12'h0, 4'hf);
        r.op.is_fence = 1'b1;
        issue(r);
        issue(make_req(1'b0, 2'd2, 1'b0, 32'h100, 12'h0, 4'hf));
        drain();
    endtask

    task automatic test_backpressure();
        int unsigned x;
        logic [1:0]  ws;
        logic [1:0]  al;
        stall_mode = 1'b1;
        repeat (100) begin
            x = lcg();
            ws = x[2:1] % 3;
            al = (ws == 2'd0) ? x[4:3] : (ws == 2'd1) ? {x[3], 1'b0} : 2'd0;
            issue(make_req(x[0], ws, x[14], 32'h500 + (x[9:5] << 4) + al, 12'h0,
                           x[13:10] | 4'b0001));
        end
        drain();
        stall_mode = 1'b0;
    endtask

    initial begin
        reset = 1'b1;
        exec_valid = 1'b0;
        exec_req = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp = '0;
        commit_ready = 1'b0;
        for (int a = 0; a < 1024; a++) begin
            mem[a] = fill_word(a);
            shadow[a] = fill_word(a);
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        test_word_access();
        test_req_format();
        test_subword_loads();
        test_partial_mask();
        test_fence();
        test_backpressure();
        repeat (4) @(negedge clk);
        // anything still arriving here was committed twice
        if (got_q.size() > 0) begin
            errors += got_q.size();
            $display("%0d commits arrived after all expected ones", got_q.size());
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* list.f */
src/lsu_pkg.sv
src/lsu_skid_buffer.sv
src/lsu_req_format.sv
src/lsu_issue_ctrl.sv
src/lsu_rsp_format.sv
src/lsu_commit_arb.sv
src/lsu_slice.sv
tests/tb_lsu_slice.sv

/* Bender.yml */
package:
  name: lsu_slice

sources:
  - src/lsu_pkg.sv
  - src/lsu_skid_buffer.sv
  - src/lsu_req_format.sv
  - src/lsu_issue_ctrl.sv
  - src/lsu_rsp_format.sv
  - src/lsu_commit_arb.sv
  - src/lsu_slice.sv
  - target: test
    files:
      - tests/tb_lsu_slice.sv
